// File: include/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath width.
`define XLEN 32

// registers visible to software.
`define NUM_ARCH_REGS 8

// reorder buffer entries, which also size the tag.
`define ROB_DEPTH 8

// issue queue entries.
`define IQ_DEPTH 4

// cycles from multiply issue to its result on the bus.
`define MUL_LATENCY 4

`endif

// File: rtl/corePkg.sv
`default_nettype none

`include "core_params.svh"

package corePkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] archReg_t;
  typedef logic [$clog2(`ROB_DEPTH)-1:0] robTag_t;
  // tag with one extra wrap bit on top.
  typedef logic [$clog2(`ROB_DEPTH):0] sqN_t;

  typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLL, SRL, MUL} aluOp_e;

  typedef struct packed {
    logic valid;
    aluOp_e op;
    logic useImm;
    archReg_t dst;
    archReg_t src1;
    archReg_t src2;
    word_t imm;
  } dispUop_t;

  typedef struct packed {
    logic valid;
    aluOp_e op;
    robTag_t tag;
    archReg_t dst;
    word_t [1:0] srcValue;
    logic [1:0] srcReady;
    robTag_t [1:0] srcTag;
  } issueUop_t;

  typedef struct packed {
    logic valid;
    robTag_t tag;
    word_t value;
  } resultBus_t;

  typedef struct packed {
    logic valid;
    sqN_t sqN;
    archReg_t dst;
    word_t value;
  } commit_t;

endpackage

`default_nettype wire

// File: rtl/renameStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module renameStage import corePkg::*; (
  input logic clk,
  input logic rstN,
  input dispUop_t inUop,
  output logic inUopReady,
  input logic robFree,
  input logic iqFree,
  output robTag_t robReadTag [2],
  input logic robReadDone [2],
  input word_t robReadValue [2],
  input resultBus_t resultBus,
  input commit_t commit,
  output issueUop_t renUop
);

  localparam int N = `NUM_ARCH_REGS;

  word_t archFile [N];
  logic [N-1:0] mapPending;
  robTag_t mapTag [N];
  sqN_t nextSqN;

  archReg_t srcReg [2];
  logic accepted;
  issueUop_t nextUop;
  issueUop_t renData;
  logic renValid;

  assign inUopReady = robFree && iqFree;
  assign accepted = inUop.valid && inUopReady;
  assign srcReg[0] = inUop.src1;
  assign srcReg[1] = inUop.src2;

  always_comb begin
    nextUop = '0;
    nextUop.valid = 1'b1;
    nextUop.op = inUop.op;
    nextUop.tag = robTag_t'(nextSqN);
    nextUop.dst = inUop.dst;
    for (int k = 0; k < 2; k++) begin
      robReadTag[k] = mapTag[srcReg[k]];
      nextUop.srcTag[k] = mapTag[srcReg[k]];
      nextUop.srcReady[k] = 1'b1;
      if (k == 1 && inUop.useImm) begin
        nextUop.srcValue[k] = inUop.imm;
      end else if (!mapPending[srcReg[k]]) begin
        nextUop.srcValue[k] = archFile[srcReg[k]];
      end else if (robReadDone[k]) begin
        nextUop.srcValue[k] = robReadValue[k];
      end else if (resultBus.valid && resultBus.tag == mapTag[srcReg[k]]) begin
        nextUop.srcValue[k] = resultBus.value;
      end else begin
        // producer still running, wake up later.
        nextUop.srcReady[k] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mapPending <= '0;
      nextSqN <= '0;
      renValid <= 1'b0;
      for (int r = 0; r < N; r++) begin
        archFile[r] <= '0;
      end
    end else begin
      renValid <= accepted;
      if (commit.valid) begin
        archFile[commit.dst] <= commit.value;
      end
      // a newer producer of the same register keeps its mapping.
      for (int r = 0; r < N; r++) begin
        if (commit.valid && mapTag[r] == robTag_t'(commit.sqN)) begin
          mapPending[r] <= 1'b0;
        end
      end
      if (accepted) begin
        mapPending[inUop.dst] <= 1'b1;
        nextSqN <= nextSqN + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accepted) begin
      mapTag[inUop.dst] <= robTag_t'(nextSqN);
      renData <= nextUop;
    end
  end

  always_comb begin
    renUop = renData;
    renUop.valid = renValid;
  end

  // a rejected micro-op is held until it is taken.
  assert property (@(posedge clk) disable iff (!rstN)
    inUop.valid && !inUopReady |=> $stable(inUop));

endmodule

`default_nettype wire

// File: rtl/issueQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module issueQueue import corePkg::*; (
  input logic clk,
  input logic rstN,
  input issueUop_t renUop,
  input resultBus_t resultBus,
  output logic iqFree,
  output issueUop_t exUop
);

  localparam int D = `IQ_DEPTH;
  localparam int IW = $clog2(D);
  localparam int CW = $clog2(D + 1);

  issueUop_t entry [D];
  logic [D-1:0] occ;
  // older[i][j] set means entry i arrived before entry j.
  logic [D-1:0] older [D];
  // bit 0 means a multiply result takes the bus next cycle.
  logic [`MUL_LATENCY-2:0] mulResv;

  logic [D-1:0] cand;
  logic [D-1:0] pick;
  logic [IW-1:0] freeIdx;
  logic [CW-1:0] nFree;

  function automatic issueUop_t wake(issueUop_t u, resultBus_t rb);
    issueUop_t w;
    w = u;
    for (int k = 0; k < 2; k++) begin
      if (rb.valid && !u.srcReady[k] && rb.tag == u.srcTag[k]) begin
        w.srcReady[k] = 1'b1;
        w.srcValue[k] = rb.value;
      end
    end
    return w;
  endfunction

  always_comb begin
    freeIdx = '0;
    nFree = '0;
    for (int i = D - 1; i >= 0; i--) begin
      if (!occ[i]) begin
        freeIdx = IW'(i);
        nFree = nFree + 1'b1;
      end
    end
  end

  // keep a slot back for the op still leaving rename.
  assign iqFree = nFree > CW'(renUop.valid);

  always_comb begin
    for (int i = 0; i < D; i++) begin
      cand[i] = occ[i] && (&entry[i].srcReady) && (entry[i].op == MUL || !mulResv[0]);
    end
    for (int i = 0; i < D; i++) begin
      pick[i] = cand[i];
      for (int j = 0; j < D; j++) begin
        if (cand[j] && older[j][i]) pick[i] = 1'b0;
      end
    end
    exUop = '0;
    for (int i = 0; i < D; i++) begin
      if (pick[i]) exUop = entry[i];
    end
    exUop.valid = |pick;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      occ <= '0;
      mulResv <= '0;
    end else begin
      occ <= occ & ~pick;
      if (renUop.valid) occ[freeIdx] <= 1'b1;
      mulResv <= mulResv >> 1;
      mulResv[`MUL_LATENCY-2] <= exUop.valid && exUop.op == MUL;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < D; i++) begin
      entry[i] <= wake(entry[i], resultBus);
    end
    if (renUop.valid) begin
      entry[freeIdx] <= wake(renUop, resultBus);
      older[freeIdx] <= '0;
      for (int j = 0; j < D; j++) begin
        if (j != freeIdx) older[j][freeIdx] <= 1'b1;
      end
    end
  end

  // the age order leaves exactly one oldest candidate.
  assert property (@(posedge clk) disable iff (!rstN)
    $onehot0(pick));

endmodule

`default_nettype wire

// File: rtl/intExecute.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module intExecute import corePkg::*; (
  input logic clk,
  input logic rstN,
  input issueUop_t exUop,
  output resultBus_t resultBus
);

  localparam int LAT = `MUL_LATENCY;
  localparam int SHW = $clog2(`XLEN);

  word_t opA;
  word_t opB;
  word_t aluResult;

  logic aluValid;
  robTag_t aluTag;
  word_t aluValue;

  logic [LAT-1:0] mulValid;
  robTag_t mulTag [LAT];
  word_t mulProd [LAT];

  assign opA = exUop.srcValue[0];
  assign opB = exUop.srcValue[1];

  always_comb begin
    case (exUop.op)
      ADD: aluResult = opA + opB;
      SUB: aluResult = opA - opB;
      AND: aluResult = opA & opB;
      OR: aluResult = opA | opB;
      XOR: aluResult = opA ^ opB;
      SLL: aluResult = opA << opB[SHW-1:0];
      SRL: aluResult = opA >> opB[SHW-1:0];
      default: aluResult = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aluValid <= 1'b0;
      mulValid <= '0;
    end else begin
      aluValid <= exUop.valid && exUop.op != MUL;
      mulValid <= {mulValid[LAT-2:0], exUop.valid && exUop.op == MUL};
    end
  end

  always_ff @(posedge clk) begin
    aluTag <= exUop.tag;
    aluValue <= aluResult;
    mulTag[0] <= exUop.tag;
    mulProd[0] <= opA * opB;
    for (int i = 1; i < LAT; i++) begin
      mulTag[i] <= mulTag[i-1];
      mulProd[i] <= mulProd[i-1];
    end
  end

  always_comb begin
    if (aluValid) begin
      resultBus = '{valid: 1'b1, tag: aluTag, value: aluValue};
    end else begin
      resultBus = '{valid: mulValid[LAT-1], tag: mulTag[LAT-1], value: mulProd[LAT-1]};
    end
  end

  // slot reservation in the issue queue keeps the two paths apart.
  assert property (@(posedge clk) disable iff (!rstN)
    !(aluValid && mulValid[LAT-1]));

endmodule

`default_nettype wire

// File: rtl/reorderBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module reorderBuffer import corePkg::*; (
  input logic clk,
  input logic rstN,
  input issueUop_t renUop,
  input resultBus_t resultBus,
  output logic robFree,
  input robTag_t robReadTag [2],
  output logic robReadDone [2],
  output word_t robReadValue [2],
  output commit_t commit
);

  localparam int D = `ROB_DEPTH;

  logic [D-1:0] busy;
  logic [D-1:0] done;
  archReg_t dstMem [D];
  word_t valueMem [D];

  sqN_t head;
  sqN_t tail;
  sqN_t count;
  robTag_t headTag;

  assign headTag = robTag_t'(head);
  assign count = tail - head;

  // an op on its way from rename already owns an entry.
  assign robFree = (count + sqN_t'(renUop.valid)) < sqN_t'(D);

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      robReadDone[k] = done[robReadTag[k]];
      robReadValue[k] = valueMem[robReadTag[k]];
    end
  end

  always_comb begin
    commit.valid = busy[headTag] && done[headTag];
    commit.sqN = head;
    commit.dst = dstMem[headTag];
    commit.value = valueMem[headTag];
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busy <= '0;
      done <= '0;
      head <= '0;
      tail <= '0;
    end else begin
      if (commit.valid) begin
        busy[headTag] <= 1'b0;
        done[headTag] <= 1'b0;
        head <= head + 1'b1;
      end
      if (resultBus.valid) begin
        done[resultBus.tag] <= 1'b1;
      end
      if (renUop.valid) begin
        busy[renUop.tag] <= 1'b1;
        done[renUop.tag] <= 1'b0;
        tail <= tail + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (renUop.valid) begin
      dstMem[renUop.tag] <= renUop.dst;
    end
    if (resultBus.valid) begin
      valueMem[resultBus.tag] <= resultBus.value;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN)
    resultBus.valid |-> busy[resultBus.tag]);

  // rename allocates in the same order as the tail moves.
  assert property (@(posedge clk) disable iff (!rstN)
    renUop.valid |-> renUop.tag == robTag_t'(tail));

endmodule

`default_nettype wire

// File: rtl/ooCore.sv
`timescale 1ns/1ps
`default_nettype none

module ooCore import corePkg::*; (
  input logic clk,
  input logic rstN,
  input dispUop_t inUop,
  output logic inUopReady,
  output commit_t commitOut
);

  issueUop_t renUop;
  issueUop_t exUop;
  resultBus_t resultBus;
  logic robFree;
  logic iqFree;
  robTag_t robReadTag [2];
  logic robReadDone [2];
  word_t robReadValue [2];

  renameStage rn (
    .clk(clk),
    .rstN(rstN),
    .inUop(inUop),
    .inUopReady(inUopReady),
    .robFree(robFree),
    .iqFree(iqFree),
    .robReadTag(robReadTag),
    .robReadDone(robReadDone),
    .robReadValue(robReadValue),
    .resultBus(resultBus),
    .commit(commitOut),
    .renUop(renUop)
  );

  issueQueue iq (
    .clk(clk),
    .rstN(rstN),
    .renUop(renUop),
    .resultBus(resultBus),
    .iqFree(iqFree),
    .exUop(exUop)
  );

  intExecute ex (
    .clk(clk),
    .rstN(rstN),
    .exUop(exUop),
    .resultBus(resultBus)
  );

  reorderBuffer rob (
    .clk(clk),
    .rstN(rstN),
    .renUop(renUop),
    .resultBus(resultBus),
    .robFree(robFree),
    .robReadTag(robReadTag),
    .robReadDone(robReadDone),
    .robReadValue(robReadValue),
    .commit(commitOut)
  );

endmodule

`default_nettype wire

// File: test/tbOoCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbOoCore import corePkg::*; ();

  localparam int RANDOM_UOPS = 240;
  localparam int CHAIN_BURSTS = 4;
  localparam int CHAIN_LEN = 12;
  localparam int STALL_LIMIT = 200;
  localparam int DRAIN_LIMIT = 1000;

  logic clk;
  logic rstN;
  dispUop_t inUop;
  logic inUopReady;
  commit_t commitOut;

  // program-order register model and the commits still expected.
  word_t refRegs [8];
  archReg_t expDstQ [$];
  word_t expValueQ [$];

  logic headValid;
  archReg_t headDst;
  word_t headValue;
  sqN_t expSqN;

  int acceptCount;
  int commitCount;
  int errorCount;
  int timeoutCount;
  logic sawStall;
  logic [31:0] rngState;

  ooCore u_dut (
    .clk(clk),
    .rstN(rstN),
    .inUop(inUop),
    .inUopReady(inUopReady),
    .commitOut(commitOut)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // result of one op as defined for the core, low word of a product.
  function automatic word_t refResult(aluOp_e op, word_t a, word_t b);
    case (op)
      ADD: return a + b;
      SUB: return a - b;
      AND: return a & b;
      OR: return a | b;
      XOR: return a ^ b;
      SLL: return a << b[4:0];
      SRL: return a >> b[4:0];
      MUL: return a * b;
      default: return '0;
    endcase
  endfunction

  function automatic dispUop_t randomUop();
    dispUop_t u;
    logic [31:0] r;
    r = nextRandom();
    u.valid = 1'b1;
    u.op = aluOp_e'(r[2:0]);
    u.useImm = r[3] & r[4];
    u.dst = r[7:5];
    u.src1 = r[10:8];
    u.src2 = r[13:11];
    u.imm = nextRandom();
    if (r[14]) begin
      u.imm = {27'd0, u.imm[4:0]};
    end
    return u;
  endfunction

  // multiply chain on one register, with an add every fourth step.
  function automatic dispUop_t chainUop(int burst, int step);
    dispUop_t u;
    u = '0;
    u.valid = 1'b1;
    u.dst = archReg_t'(burst + 1);
    u.src1 = archReg_t'(burst + 1);
    u.src2 = archReg_t'(burst + 1);
    if (step == 0) begin
      u.op = ADD;
      u.src1 = '0;
      u.useImm = 1'b1;
      u.imm = word_t'(burst + 2);
    end else if (step % 4 == 3) begin
      u.op = ADD;
    end else begin
      u.op = MUL;
      u.useImm = 1'b1;
      u.imm = word_t'(burst + 3);
    end
    return u;
  endfunction

  // called on a rising edge, returns on the edge that accepts the op.
  task automatic sendUop(input dispUop_t u);
    int waited;
    waited = 0;
    if (timeoutCount == 0) begin
      inUop <= u;
      @(negedge clk);
      while (!inUopReady && waited < STALL_LIMIT) begin
        sawStall = 1'b1;
        waited++;
        @(negedge clk);
      end
      if (!inUopReady) begin
        timeoutCount++;
        $display("Timeout: inUopReady stayed low for %0d cycles at %0t", STALL_LIMIT, $time);
      end
      @(posedge clk);
    end
  endtask

  task automatic idleCycles(input int n);
    inUop <= '0;
    repeat (n) @(posedge clk);
  endtask

  // mid-cycle view of what the next rising edge accepts and commits.
  always @(negedge clk) begin
    word_t opB;
    word_t result;
    headValid = (expDstQ.size() > 0);
    if (headValid) begin
      headDst = expDstQ[0];
      headValue = expValueQ[0];
    end
    expSqN = sqN_t'(commitCount);
    if (rstN && commitOut.valid) begin
      commitCount++;
      if (headValid) begin
        void'(expDstQ.pop_front());
        void'(expValueQ.pop_front());
      end
    end
    if (rstN && inUop.valid && inUopReady) begin
      opB = inUop.useImm ? inUop.imm : refRegs[inUop.src2];
      result = refResult(inUop.op, refRegs[inUop.src1], opB);
      refRegs[inUop.dst] = result;
      expDstQ.push_back(inUop.dst);
      expValueQ.push_back(result);
      acceptCount++;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN)
    commitOut.valid |-> headValid)
  else begin
    errorCount++;
    $display("Commit seen at %0t with no accepted micro-op outstanding", $time);
  end

  assert property (@(posedge clk) disable iff (!rstN)
    commitOut.valid && headValid |-> commitOut.dst == headDst && commitOut.value == headValue)
  else begin
    errorCount++;
    $display("** Error at %0t: commit r%0d = %h, expected r%0d = %h", $time,
      $sampled(commitOut.dst), $sampled(commitOut.value), headDst, headValue);
  end

  assert property (@(posedge clk) disable iff (!rstN)
    commitOut.valid |-> commitOut.sqN == expSqN)
  else begin
    errorCount++;
    $display("** Error at %0t: commit sqN %0d, expected %0d", $time,
      $sampled(commitOut.sqN), expSqN);
  end

  assert property (@(posedge clk) disable iff (!rstN)
    acceptCount == 0 |-> !commitOut.valid)
  else begin
    errorCount++;
    $display("Commit seen at %0t before any micro-op was accepted", $time);
  end

  assert property (@(posedge clk) $rose(rstN) |-> inUopReady)
  else begin
    errorCount++;
    $display("inUopReady was low on the first cycle after reset at %0t", $time);
  end

  initial begin
    int waited;
    rngState = 32'd1392;
    rstN = 1'b0;
    inUop = '0;
    acceptCount = 0;
    commitCount = 0;
    errorCount = 0;
    timeoutCount = 0;
    sawStall = 1'b0;
    for (int r = 0; r < 8; r++) begin
      refRegs[r] = '0;
    end
    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    for (int n = 0; n < RANDOM_UOPS; n++) begin
      sendUop(randomUop());
      if (nextRandom() % 4 == 0) begin
        idleCycles(1 + int'(nextRandom() % 3));
      end
    end

    // dependent multiplies fill the queues and force stalls.
    for (int b = 0; b < CHAIN_BURSTS; b++) begin
      for (int n = 0; n < CHAIN_LEN; n++) begin
        sendUop(chainUop(b, n));
      end
      idleCycles(2);
    end

    idleCycles(1);
    waited = 0;
    while (commitCount != acceptCount && waited < DRAIN_LIMIT && timeoutCount == 0) begin
      @(posedge clk);
      waited++;
    end
    if (commitCount != acceptCount && timeoutCount == 0) begin
      timeoutCount++;
      $display("Timeout: commits did not drain within %0d cycles", DRAIN_LIMIT);
    end
    repeat (2) @(posedge clk);

    assert (commitCount == acceptCount) else begin
      errorCount++;
      $display("** Error at %0t: %0d commits for %0d accepted micro-ops", $time,
        commitCount, acceptCount);
    end
    assert (sawStall) else begin
      errorCount++;
      $display("Back-pressure never seen, inUopReady did not drop");
    end

    $display("errors: %0d, timeouts: %0d, accepted: %0d, committed: %0d",
      errorCount, timeoutCount, acceptCount, commitCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
rtl/corePkg.sv
rtl/renameStage.sv
rtl/issueQueue.sv
rtl/intExecute.sv
rtl/reorderBuffer.sv
rtl/ooCore.sv
test/tbOoCore.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f list.f --top-module tbOoCore -o simOoCore

./obj_dir/simOoCore | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
else
  exit 1
fi
